//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TB_TOP = tb_riscv_core
RTL_TOP = riscv_core
FILELIST = riscv_core.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- riscv_core.f
+incdir+verification
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_core.sv
verification/tb_riscv_core.sv

//--- verification/tb_prog_gen.svh
`ifndef TB_PROG_GEN_SVH
`define TB_PROG_GEN_SVH

// Program image and the output words it must produce, in order
logic [31:0] prog_q[$];
logic [31:0] expect_q[$];

localparam logic [6:0] I_ALU = 7'b0010011;
localparam logic [6:0] I_LOAD = 7'b0000011;
localparam logic [6:0] I_JALR = 7'b1100111;
localparam logic [31:0] NOP_WORD = 32'h0000_0013;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// Always a word store
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic void emit(input logic [31:0] w);
    prog_q.push_back(w);
endfunction

// Byte address of the next emitted word, program starts at zero
function automatic logic [31:0] pc_now();
    return prog_q.size() * 4;
endfunction

// LUI plus ADDI, upper part rounded for the sign of the low 12 bits
function automatic void load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] upper;
    upper = val + 32'h0000_0800;
    emit(enc_u(upper[31:12], rd));
    emit(enc_i(val[11:0], rd, 3'b000, rd, I_ALU));
endfunction

// x31 holds 0x8000_0000, so offset 8 hits the output word
function automatic void emit_output(input logic [4:0] rs, input logic [31:0] expected);
    emit(enc_s(12'd8, rs, 5'd31));
    expect_q.push_back(expected);
endfunction

function automatic void begin_program();
    prog_q.delete();
    expect_q.delete();
    emit(enc_u(20'h80000, 5'd31));
endfunction

// Park the core in a jump-to-self
function automatic void end_program();
    emit(enc_j(21'd0, 5'd0));
endfunction

// RV32I integer result by funct3, alt is instruction bit 30
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input bit alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << sh;
        3'd2: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        3'd3: r = {31'd0, a < b};
        3'd4: r = a ^ b;
        // Arithmetic shift refills with copies of the sign bit
        3'd5: r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
    bit lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return lt_s;
        3'd5: return !lt_s;
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

`endif

//--- verification/tb_riscv_core.sv
`default_nettype none

module tb_riscv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam logic [31:0] SEED = 32'hb520_7b15;

    logic clk;
    logic rst;
    logic run;
    logic prog_valid;
    logic [31:0] prog_word;
    logic prog_ready;
    logic out_valid;
    logic [31:0] out_data;
    logic out_ready;

    // Random out_ready while set
    bit random_ready;
    // Watchdog limit that each test moves forward
    time deadline = 64'd4000;
    logic [31:0] exp_word;
    logic [31:0] seed_val;

    `include "tb_prog_gen.svh"

    riscv_core #(
        .RESET_PC(32'h0000_0000),
        .IMEM_WORDS(1024),
        .DMEM_WORDS(1024)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .run(run),
        .prog_valid(prog_valid),
        .prog_word(prog_word),
        .prog_ready(prog_ready),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Sink ready about two cycles in three under back-pressure
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = random_ready ? ($urandom % 3 != 0) : 1'b1;
        end
    end

    // Handshake is stable from negedge to the accepting posedge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (expect_q.size() != 0)
                else abort_run($sformatf("unexpected output word %h at %0d ns", out_data, $time));
            exp_word = expect_q.pop_front();
            assert (out_data == exp_word)
                else abort_run($sformatf("mismatch at %0d ns: out_data expected %h observed %h",
                                         $time, exp_word, out_data));
        end
    end

    initial begin
        while ($time < deadline) begin
            @(negedge clk);
        end
        abort_run("timeout: the core did not deliver every expected output in time");
    end

    task automatic reset_core();
        rst = 1'b1;
        run = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (out_valid == 1'b0)
            else abort_run($sformatf("mismatch at %0d ns: out_valid expected 0 observed %b",
                                     $time, out_valid));
        assert (prog_ready == 1'b1)
            else abort_run($sformatf("mismatch at %0d ns: prog_ready expected 1 observed %b",
                                     $time, prog_ready));
        @(posedge clk);
        #1;
    endtask

    task automatic load_and_run(input string name);
        deadline = $time + (40 * prog_q.size() + 200) * CLK_PERIOD;
        reset_core();
        foreach (prog_q[i]) begin
            prog_valid = 1'b1;
            prog_word = prog_q[i];
            @(posedge clk);
            #1;
        end
        prog_valid = 1'b0;
        run = 1'b1;
        @(negedge clk);
        assert (prog_ready == 1'b0)
            else abort_run($sformatf("mismatch at %0d ns: prog_ready expected 0 observed %b",
                                     $time, prog_ready));
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        // Idle window to catch a stray or repeated word
        repeat (20) @(posedge clk);
        #1;
        run = 1'b0;
        $display("%s: all outputs matched", name);
    endtask

    // Result in x3 from x1 and x2 or an immediate and stored at once or after one bubble
    task automatic add_alu_case(input bit use_imm, input logic [2:0] f3, input bit alt,
                                input bit gap);
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        a = $urandom;
        b = $urandom;
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, alt, 5'd0, imm[4:0]};
        end
        load_const(5'd1, a);
        if (use_imm) begin
            b = {{20{imm[11]}}, imm};
            emit(enc_i(imm, 5'd1, f3, 5'd3, I_ALU));
        end else begin
            load_const(5'd2, b);
            emit(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd3));
        end
        if (gap) begin
            emit(NOP_WORD);
        end
        emit_output(5'd3, ref_alu(f3, alt, a, b));
    endtask

    task automatic add_alu_cases();
        for (int f = 0; f < 8; f++) begin
            add_alu_case(1'b0, 3'(f), 1'b0, f % 2 == 1);
            add_alu_case(1'b1, 3'(f), 1'b0, f % 2 == 0);
        end
        // sub, sra, srai
        add_alu_case(1'b0, 3'd0, 1'b1, 1'b0);
        add_alu_case(1'b0, 3'd5, 1'b1, 1'b1);
        add_alu_case(1'b1, 3'd5, 1'b1, 1'b0);
    endtask

    // Store all words first, then load each and output it at once
    task automatic add_mem_cases();
        logic [31:0] addr [6];
        logic [31:0] data [6];
        for (int k = 0; k < 6; k++) begin
            addr[k] = 32'h1000_0000 + (k * 128 + $urandom % 128) * 4;
            data[k] = $urandom;
            load_const(5'd1, addr[k] + 32'd4);
            load_const(5'd2, data[k]);
            emit(enc_s(12'hffc, 5'd2, 5'd1));
        end
        for (int k = 0; k < 6; k++) begin
            load_const(5'd1, addr[k]);
            emit(enc_i(12'd0, 5'd1, 3'b010, 5'd4, I_LOAD));
            emit_output(5'd4, data[k]);
        end
    endtask

    task automatic add_branch_case(input logic [2:0] f3, input int n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mark_taken;
        logic [31:0] mark_fall;
        a = $urandom;
        b = ($urandom % 4 == 0) ? a : $urandom;
        mark_taken = 32'h7a4e_0000 | n;
        mark_fall = 32'hfa11_0000 | n;
        load_const(5'd1, a);
        load_const(5'd2, b);
        load_const(5'd5, mark_fall);
        load_const(5'd6, mark_taken);
        // Taken path skips the fall-through store and its jump
        emit(enc_b(13'd12, 5'd2, 5'd1, f3));
        emit(enc_s(12'd8, 5'd5, 5'd31));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_s(12'd8, 5'd6, 5'd31));
        expect_q.push_back(ref_branch(f3, a, b) ? mark_taken : mark_fall);
    endtask

    task automatic add_branch_cases();
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int k = 0; k < 12; k++) begin
            add_branch_case(conds[k % 6], k);
        end
    endtask

    task automatic add_jump_cases();
        logic [31:0] link;
        logic [31:0] target;
        load_const(5'd5, 32'hbad0_0bad);
        link = pc_now() + 32'd4;
        emit(enc_j(21'd12, 5'd7));
        emit(enc_s(12'd8, 5'd5, 5'd31));
        emit(enc_s(12'd8, 5'd5, 5'd31));
        emit_output(5'd7, link);
        // Odd sum lands on target once bit 0 is cleared
        target = pc_now() + 32'd20;
        load_const(5'd8, target);
        link = pc_now() + 32'd4;
        emit(enc_i(12'd1, 5'd8, 3'b000, 5'd9, I_JALR));
        emit(enc_s(12'd8, 5'd5, 5'd31));
        emit(enc_s(12'd8, 5'd5, 5'd31));
        emit_output(5'd9, link);
    endtask

    initial begin
        seed_val = $urandom(SEED);
        rst = 1'b1;
        run = 1'b0;
        prog_valid = 1'b0;
        prog_word = 32'd0;
        random_ready = 1'b0;
        begin_program();
        add_alu_cases();
        end_program();
        load_and_run("alu");
        begin_program();
        add_mem_cases();
        end_program();
        load_and_run("data memory");
        begin_program();
        add_branch_cases();
        end_program();
        load_and_run("branches");
        begin_program();
        add_jump_cases();
        end_program();
        load_and_run("jumps");
        // Same mix again with a stalling sink
        begin_program();
        add_alu_cases();
        add_mem_cases();
        add_branch_cases();
        add_jump_cases();
        end_program();
        random_ready = 1'b1;
        load_and_run("back-pressure");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage import rv_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic stall,
    input wire logic flush,
    input wire word_t pc,
    input wire word_t inst,
    input wire logic wb_wen,
    input wire reg_addr_t wb_rd,
    input wire word_t wb_val,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input wire word_t rs1_data,
    input wire word_t rs2_data,
    output x_stage_t x_out
);

    // Shared by OP and OP_IMM, sub only exists for OP
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt,
                                                input logic allow_sub);
        alu_op_e op;
        case (f3)
            3'b000: op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    opcode_e opcode;
    ctrl_t ctrl;
    word_t imm;
    x_stage_t x_next;

    assign opcode = opcode_e'(inst[6:0]);
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        ctrl = NOP_CTRL;
        ctrl.funct3 = inst[14:12];
        ctrl.rd = inst[11:7];
        // I format by default
        imm = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = alu_from_funct3(inst[14:12], inst[30], 1'b1);
                ctrl.b_is_imm = 1'b0;
                ctrl.reg_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op = alu_from_funct3(inst[14:12], inst[30], 1'b0);
                ctrl.reg_wen = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
                imm = {inst[31:12], 12'b0};
            end
            OPC_LOAD: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_MEM;
                ctrl.is_load = 1'b1;
            end
            OPC_STORE: begin
                ctrl.is_store = 1'b1;
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.b_is_imm = 1'b0;
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                // ALU forms pc + imm, which is the target
                ctrl.a_is_pc = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.is_jump = 1'b1;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.is_jump = 1'b1;
            end
            default: begin
                ctrl = NOP_CTRL;
            end
        endcase
        // Writes to x0 are dropped here, so later stages never match on it
        if (ctrl.rd == '0) begin
            ctrl.reg_wen = 1'b0;
        end
    end

    always_comb begin
        x_next.pc = pc;
        x_next.rs1 = rs1_addr;
        x_next.rs2 = rs2_addr;
        x_next.imm = imm;
        x_next.ctrl = ctrl;
        // Same-cycle write-back bypass
        x_next.rs1_val = (wb_wen && wb_rd != '0 && wb_rd == rs1_addr) ? wb_val : rs1_data;
        x_next.rs2_val = (wb_wen && wb_rd != '0 && wb_rd == rs2_addr) ? wb_val : rs2_data;
    end

    // Stall wins over flush so a held branch keeps its redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            x_out.ctrl <= NOP_CTRL;
        end else if (!stall) begin
            x_out <= x_next;
            if (flush) begin
                x_out.ctrl <= NOP_CTRL;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage import rv_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic stall,
    input wire x_stage_t x_in,
    input wire logic mw_wen,
    input wire reg_addr_t mw_rd,
    input wire word_t mw_val,
    output logic redirect,
    output word_t redirect_pc,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic dmem_we,
    output mw_stage_t mw_out
);

    word_t rs1_v;
    word_t rs2_v;
    word_t op_a;
    word_t op_b;
    word_t alu_y;
    logic taken;

    // Forward from memory/writeback, x0 never written so no match there
    assign rs1_v = (mw_wen && mw_rd == x_in.rs1) ? mw_val : x_in.rs1_val;
    assign rs2_v = (mw_wen && mw_rd == x_in.rs2) ? mw_val : x_in.rs2_val;

    assign op_a = x_in.ctrl.a_is_pc ? x_in.pc : rs1_v;
    assign op_b = x_in.ctrl.b_is_imm ? x_in.imm : rs2_v;

    always_comb begin
        alu_y = '0;
        case (x_in.ctrl.alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_SLL: alu_y = op_a << op_b[4:0];
            ALU_SLT: alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_y = {31'b0, op_a < op_b};
            ALU_XOR: alu_y = op_a ^ op_b;
            ALU_SRL: alu_y = op_a >> op_b[4:0];
            ALU_SRA: alu_y = $signed(op_a) >>> op_b[4:0];
            ALU_OR: alu_y = op_a | op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_PASS_B: alu_y = op_b;
            default: alu_y = '0;
        endcase
    end

    // Condition from funct3, always on the register values
    always_comb begin
        case (x_in.ctrl.funct3)
            3'b000: taken = rs1_v == rs2_v;
            3'b001: taken = rs1_v != rs2_v;
            3'b100: taken = $signed(rs1_v) < $signed(rs2_v);
            3'b101: taken = $signed(rs1_v) >= $signed(rs2_v);
            3'b110: taken = rs1_v < rs2_v;
            3'b111: taken = rs1_v >= rs2_v;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = x_in.ctrl.is_jump || (x_in.ctrl.is_branch && taken);
    // Jumps take the ALU sum, bit 0 dropped for JALR
    assign redirect_pc = x_in.ctrl.is_branch ? x_in.pc + x_in.imm : {alu_y[31:1], 1'b0};

    // Address goes out now, load data comes back next cycle
    assign dmem_addr = alu_y;
    assign dmem_wdata = rs2_v;
    assign dmem_we = x_in.ctrl.is_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            mw_out.ctrl <= NOP_CTRL;
        end else if (!stall) begin
            mw_out.pc <= x_in.pc;
            mw_out.alu <= alu_y;
            mw_out.store_data <= rs2_v;
            mw_out.ctrl <= x_in.ctrl;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000,
    parameter int IMEM_WORDS = 1024
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic run,
    input wire logic stall,
    input wire logic redirect,
    input wire word_t redirect_pc,
    input wire logic prog_valid,
    input wire word_t prog_word,
    output logic prog_ready,
    output word_t pc,
    output word_t inst
);

    localparam int IW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t inst_q;
    word_t next_pc;
    logic [IW-1:0] load_cnt;
    logic load_fire;

    // Loader owns the memory only while the core is parked
    assign prog_ready = !run;
    assign load_fire = prog_valid && prog_ready;

    // Parked PC, then hold on stall, then redirect, then sequential
    always_comb begin
        if (rst || !run) begin
            next_pc = RESET_PC;
        end else if (stall) begin
            next_pc = pc;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            load_cnt <= '0;
        end else begin
            pc <= next_pc;
            if (load_fire) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    // Read at next_pc so the word lines up with pc one edge later
    always_ff @(posedge clk) begin
        if (load_fire) begin
            imem[load_cnt] <= prog_word;
        end
        inst_q <= imem[next_pc[IW+1:2]];
    end

    // Idle core sees only no-ops
    assign inst = run ? inst_q : NOP_INST;

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage import rv_pkg::*; #(
    parameter int DMEM_WORDS = 1024
) (
    input wire logic clk,
    input wire logic rst,
    input wire mw_stage_t mw_in,
    input wire word_t dmem_addr,
    input wire word_t dmem_wdata,
    input wire logic dmem_we,
    output logic out_valid,
    output word_t out_data,
    input wire logic out_ready,
    output logic stall,
    output logic wb_wen,
    output reg_addr_t wb_rd,
    output word_t wb_val
);

    localparam int DW = $clog2(DMEM_WORDS);

    word_t dmem [DMEM_WORDS];
    word_t rdata_q;
    logic rd_hit_q;
    logic dmem_sel;
    word_t mem_data;

    // Bit 28 set with bit 31 clear
    assign dmem_sel = dmem_addr[DMEM_BASE_BIT] && !dmem_addr[31];

    always_ff @(posedge clk) begin
        if (dmem_we && dmem_sel) begin
            dmem[dmem_addr[DW+1:2]] <= dmem_wdata;
        end
        rdata_q <= dmem[dmem_addr[DW+1:2]];
        rd_hit_q <= dmem_sel;
    end

    // Loads outside data memory read as zero
    assign mem_data = (mw_in.ctrl.is_load && rd_hit_q) ? rdata_q : '0;

    // Flag follows the store into memory/writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= dmem_we && dmem_addr == OUT_ADDR;
        end
    end

    // Held stable by the stall while not accepted
    assign out_data = mw_in.store_data;
    assign stall = out_valid && !out_ready;

    assign wb_wen = mw_in.ctrl.reg_wen;
    assign wb_rd = mw_in.ctrl.rd;

    always_comb begin
        case (mw_in.ctrl.wb_sel)
            WB_MEM: wb_val = mem_data;
            WB_PC4: wb_val = mw_in.pc + 32'd4;
            default: wb_val = mw_in.alu;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
    input wire logic clk,
    input wire logic wen,
    input wire reg_addr_t wa,
    input wire word_t wd,
    input wire reg_addr_t ra1,
    input wire reg_addr_t ra2,
    output word_t rd1,
    output word_t rd2
);

    // No storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- verilog/riscv_core.sv
`default_nettype none

module riscv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000,
    parameter int IMEM_WORDS = 1024,
    parameter int DMEM_WORDS = 1024
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic run,
    input wire logic prog_valid,
    input wire word_t prog_word,
    output logic prog_ready,
    output logic out_valid,
    output word_t out_data,
    input wire logic out_ready
);

    // Hazard and redirect
    logic stall;
    logic redirect;
    word_t redirect_pc;

    // Fetch/decode
    word_t fd_pc;
    word_t fd_inst;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;

    // Stage registers
    x_stage_t x_reg;
    mw_stage_t mw_reg;

    // Data memory access, presented from execute
    word_t dmem_addr;
    word_t dmem_wdata;
    logic dmem_we;

    // Write-back
    logic wb_wen;
    reg_addr_t wb_rd;
    word_t wb_val;

    fetch_stage #(
        .RESET_PC(RESET_PC),
        .IMEM_WORDS(IMEM_WORDS)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .run(run),
        .stall(stall),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .prog_valid(prog_valid),
        .prog_word(prog_word),
        .prog_ready(prog_ready),
        .pc(fd_pc),
        .inst(fd_inst)
    );

    // Redirect doubles as the decode flush
    decode_stage u_decode (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .flush(redirect),
        .pc(fd_pc),
        .inst(fd_inst),
        .wb_wen(wb_wen),
        .wb_rd(wb_rd),
        .wb_val(wb_val),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .x_out(x_reg)
    );

    reg_file u_rf (
        .clk(clk),
        .wen(wb_wen),
        .wa(wb_rd),
        .wd(wb_val),
        .ra1(rs1_addr),
        .ra2(rs2_addr),
        .rd1(rs1_data),
        .rd2(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .x_in(x_reg),
        .mw_wen(wb_wen),
        .mw_rd(wb_rd),
        .mw_val(wb_val),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we),
        .mw_out(mw_reg)
    );

    mem_wb_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_mem_wb (
        .clk(clk),
        .rst(rst),
        .mw_in(mw_reg),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_ready(out_ready),
        .stall(stall),
        .wb_wen(wb_wen),
        .wb_rd(wb_rd),
        .wb_val(wb_val)
    );

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic a_is_pc;
        logic b_is_imm;
        logic reg_wen;
        wb_sel_e wb_sel;
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_jump;
        // Branch condition for BRANCH
        logic [2:0] funct3;
        reg_addr_t rd;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        word_t pc;
        word_t rs1_val;
        word_t rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t imm;
        ctrl_t ctrl;
    } x_stage_t;

    // Execute to memory/writeback
    typedef struct packed {
        word_t pc;
        word_t alu;
        word_t store_data;
        ctrl_t ctrl;
    } mw_stage_t;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

    // Control that NOP_INST decodes to, no writes and no redirect
    localparam ctrl_t NOP_CTRL = '{
        alu_op: ALU_ADD,
        a_is_pc: 1'b0,
        b_is_imm: 1'b1,
        reg_wen: 1'b0,
        wb_sel: WB_ALU,
        is_load: 1'b0,
        is_store: 1'b0,
        is_branch: 1'b0,
        is_jump: 1'b0,
        funct3: 3'b000,
        rd: 5'd0
    };

    // Memory map
    localparam word_t OUT_ADDR = 32'h8000_0008;
    localparam int DMEM_BASE_BIT = 28;

endpackage

`default_nettype wire
